// File: rtl/csa_pkg.sv
package csa_pkg;

	// block word, times and times_start
	typedef logic [31:0] word_t;

	// input word and result, eight bytes
	typedef logic [63:0] csa_word_t;

	// packed job is {block, in, times, times_start}
	localparam int job_width = 160;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_load,
		st_run,
		st_done
	} calc_state_t;

	// nonlinear byte step of one round
	function automatic logic [7:0] byte_mix(input logic [7:0] b, input logic [7:0] r);
		logic [7:0] rot1;
		logic [7:0] rot2;
		rot1 = {b[6:0], b[7]};
		rot2 = {b[5:0], b[7:6]};
		return b ^ (rot1 & rot2) ^ r;
	endfunction

	function automatic csa_word_t rotl64(input csa_word_t w, input logic [5:0] n);
		logic [127:0] dbl;
		dbl = {w, w} << n;
		return dbl[127:64];
	endfunction

endpackage

// File: rtl/csa_job_fifo.sv
`timescale 1ns/10ps

module csa_job_fifo #(
	parameter int depth = 8
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr_i,
	input  logic [csa_pkg::job_width-1:0] wdata_i,
	input  logic                          ren_i,
	output logic [csa_pkg::job_width-1:0] rdata_o,
	output logic                          ready_o
);
	import csa_pkg::*;

	localparam int ptr_w = $clog2(depth);

	logic [job_width-1:0] mem [depth];
	logic [ptr_w-1:0]     wr_ptr;
	logic [ptr_w-1:0]     rd_ptr;
	logic [ptr_w:0]       count;
	logic                 full;
	logic                 do_wr;
	logic                 do_rd;

	// depth is a power of two, so the top count bit means full
	assign full    = count[ptr_w];
	assign ready_o = (count != '0);
	assign do_wr   = wr_i && !full;
	assign do_rd   = ren_i && ready_o;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	// head entry stays on rdata_o until the next pop
	always_ff @(posedge clk) begin
		if (do_rd) begin
			rdata_o <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_wr, do_rd})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

// File: rtl/csa_round.sv
`timescale 1ns/10ps

module csa_round (
	input  csa_pkg::csa_word_t state_i,
	input  csa_pkg::csa_word_t key_i,
	input  csa_pkg::word_t     round_idx_i,
	output csa_pkg::csa_word_t state_o
);
	import csa_pkg::*;

	csa_word_t  mixed;
	csa_word_t  rotated;
	csa_word_t  key_rot;
	logic [7:0] r;
	logic [5:0] key_shift;

	// only the low byte of the index enters the mix
	assign r = round_idx_i[7:0];

	// key turns by whole bytes, r mod 8 of them
	assign key_shift = {round_idx_i[2:0], 3'b000};

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			mixed[8*i +: 8] = byte_mix(state_i[8*i +: 8], r);
		end
	end

	assign rotated = rotl64(mixed, 6'd8);
	assign key_rot = rotl64(key_i, key_shift);
	assign state_o = rotated ^ key_rot;

endmodule

// File: rtl/csa_calc_logic.sv
`timescale 1ns/10ps

module csa_calc_logic (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          fifo_ready_i,
	output logic                          fifo_ren_o,
	input  logic [csa_pkg::job_width-1:0] job_i,
	output logic                          calc_ready_o,
	output csa_pkg::word_t                calc_block_o,
	output csa_pkg::csa_word_t            calc_in_o,
	output csa_pkg::word_t                calc_times_o,
	output csa_pkg::word_t                calc_times_start_o,
	output csa_pkg::csa_word_t            calc_out_o
);
	import csa_pkg::*;

	calc_state_t state;

	word_t     job_block;
	csa_word_t job_in;
	word_t     job_times;
	word_t     job_times_start;

	word_t     block_q;
	csa_word_t in_q;
	word_t     times_q;
	word_t     times_start_q;
	csa_word_t key_q;
	csa_word_t cur_q;
	word_t     cnt_q;
	csa_word_t round_out;

	logic run_needed;
	logic last_round;

	// job layout {block, in, times, times_start}
	assign job_block       = job_i[159:128];
	assign job_in          = job_i[127:64];
	assign job_times       = job_i[63:32];
	assign job_times_start = job_i[31:0];

	assign run_needed = (job_times > job_times_start);
	assign last_round = (cnt_q + 32'd1 == times_q);

	assign fifo_ren_o   = (state == st_idle) && fifo_ready_i;
	assign calc_ready_o = (state == st_done);

	csa_round i_round (
		.state_i     (cur_q),
		.key_i       (key_q),
		.round_idx_i (cnt_q),
		.state_o     (round_out)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (fifo_ready_i) begin
						state <= st_fetch;
					end
				end
				// waiting on the FIFO read register
				st_fetch: begin
					state <= st_load;
				end
				st_load: begin
					state <= run_needed ? st_run : st_done;
				end
				st_run: begin
					if (last_round) begin
						state <= st_done;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// job capture and round iteration
	always_ff @(posedge clk) begin
		if (state == st_load) begin
			block_q       <= job_block;
			in_q          <= job_in;
			times_q       <= job_times;
			times_start_q <= job_times_start;
			key_q         <= {job_block, ~job_block};
			cur_q         <= job_in;
			cnt_q         <= job_times_start;
		end else if (state == st_run) begin
			cur_q <= round_out;
			cnt_q <= cnt_q + 32'd1;
		end
	end

	// results are written on the way into st_done and hold until the next job
	always_ff @(posedge clk) begin
		if (state == st_load && !run_needed) begin
			calc_block_o       <= job_block;
			calc_in_o          <= job_in;
			calc_times_o       <= job_times;
			calc_times_start_o <= job_times_start;
			calc_out_o         <= job_in;
		end else if (state == st_run && last_round) begin
			calc_block_o       <= block_q;
			calc_in_o          <= in_q;
			calc_times_o       <= times_q;
			calc_times_start_o <= times_start_q;
			calc_out_o         <= round_out;
		end
	end

endmodule

// File: rtl/csa_calc_top.sv
`timescale 1ns/10ps

module csa_calc_top #(
	parameter int fifo_depth = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               job_wr_i,
	input  csa_pkg::word_t     job_block_i,
	input  csa_pkg::csa_word_t job_in_i,
	input  csa_pkg::word_t     job_times_i,
	input  csa_pkg::word_t     job_times_start_i,
	output logic               calc_ready_o,
	output csa_pkg::word_t     calc_block_o,
	output csa_pkg::csa_word_t calc_in_o,
	output csa_pkg::word_t     calc_times_o,
	output csa_pkg::word_t     calc_times_start_o,
	output csa_pkg::csa_word_t calc_out_o
);
	import csa_pkg::*;

	logic [job_width-1:0] job_wdata;
	logic [job_width-1:0] job_rdata;
	logic                 fifo_ready;
	logic                 fifo_ren;

	assign job_wdata = {job_block_i, job_in_i, job_times_i, job_times_start_i};

	csa_job_fifo #(
		.depth (fifo_depth)
	) i_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_i    (job_wr_i),
		.wdata_i (job_wdata),
		.ren_i   (fifo_ren),
		.rdata_o (job_rdata),
		.ready_o (fifo_ready)
	);

	csa_calc_logic i_calc (
		.clk                (clk),
		.rst_n              (rst_n),
		.fifo_ready_i       (fifo_ready),
		.fifo_ren_o         (fifo_ren),
		.job_i              (job_rdata),
		.calc_ready_o       (calc_ready_o),
		.calc_block_o       (calc_block_o),
		.calc_in_o          (calc_in_o),
		.calc_times_o       (calc_times_o),
		.calc_times_start_o (calc_times_start_o),
		.calc_out_o         (calc_out_o)
	);

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
	parameter real period_ns = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(period_ns / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

// File: tb/csa_calc_sva.sv
`timescale 1ns/10ps

module csa_calc_sva (
	input logic clk,
	input logic rst_n,
	input logic fifo_ready_i,
	input logic fifo_ren_o,
	input logic calc_ready_o
);

	int fail_count = 0;

	// read strobe lasts one cycle
	ren_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |=> !fifo_ren_o
	) else begin
		fail_count++;
		$error("fifo_ren stayed high for more than one cycle");
	end

	ren_needs_data: assert property (
		@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |-> fifo_ready_i
	) else begin
		fail_count++;
		$error("fifo_ren raised while the FIFO was empty");
	end

	ready_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		calc_ready_o |=> !calc_ready_o
	) else begin
		fail_count++;
		$error("calc_ready_o stayed high for more than one cycle");
	end

	// from the second reset cycle on, state is defined
	quiet_in_reset: assert property (
		@(posedge clk)
		(!rst_n ##1 !rst_n) |-> (!fifo_ren_o && !calc_ready_o)
	) else begin
		fail_count++;
		$error("a strobe was high during reset");
	end

endmodule

// File: tb/csa_calc_tb.sv
`timescale 1ns/10ps

module csa_calc_tb;
	import csa_pkg::*;

	localparam int clk_period_ns = 4;
	localparam int reset_cycles  = 8;
	localparam int stream_jobs   = 7;
	localparam int max_times     = 30;
	localparam int margin_cycles = 200;
	// jobs x (times + 10) cycles per test, plus reset, idle test and margin
	localparam int watchdog_ns = clk_period_ns * (reset_cycles + 20 + 1 * (9 + 10)
		+ 2 * (6 + 10) + 2 * (7 + 10) + stream_jobs * (max_times + 10) + margin_cycles);

	logic      clk;
	logic      rst_n;
	logic      job_wr;
	word_t     job_block;
	csa_word_t job_in;
	word_t     job_times;
	word_t     job_times_start;
	logic      calc_ready;
	word_t     calc_block;
	csa_word_t calc_in;
	word_t     calc_times;
	word_t     calc_times_start;
	csa_word_t calc_out;

	word_t     exp_block[$];
	csa_word_t exp_in[$];
	word_t     exp_times[$];
	word_t     exp_start[$];

	string     cur_test = "init";
	int        errors = 0;
	int        checks = 0;
	int        sva_fails = 0;
	integer    seed = 48;
	logic      in_stream = 1'b0;
	logic      have_prev = 1'b0;
	csa_word_t prev_in;

	clk_gen #(.period_ns(clk_period_ns)) i_clk (.clk_o(clk));

	csa_calc_top #(.fifo_depth(8)) i_dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.job_wr_i           (job_wr),
		.job_block_i        (job_block),
		.job_in_i           (job_in),
		.job_times_i        (job_times),
		.job_times_start_i  (job_times_start),
		.calc_ready_o       (calc_ready),
		.calc_block_o       (calc_block),
		.calc_in_o          (calc_in),
		.calc_times_o       (calc_times),
		.calc_times_start_o (calc_times_start),
		.calc_out_o         (calc_out)
	);

	bind csa_calc_logic csa_calc_sva i_sva (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_ready_i (fifo_ready_i),
		.fifo_ren_o   (fifo_ren_o),
		.calc_ready_o (calc_ready_o)
	);

	// one round: byte mix, rotate by a byte, xor with the turned key
	function automatic csa_word_t model_round(input csa_word_t s, input csa_word_t k,
		input word_t idx);
		csa_word_t  m;
		csa_word_t  kr;
		logic [7:0] b;
		m = '0;
		kr = k;
		for (int i = 0; i < 8; i++) begin
			b = s[8*i +: 8];
			m[8*i +: 8] = b ^ ({b[6:0], b[7]} & {b[5:0], b[7:6]}) ^ idx[7:0];
		end
		m = {m[55:0], m[63:56]};
		for (int j = 0; j < int'(idx[2:0]); j++) begin
			kr = {kr[55:0], kr[63:56]};
		end
		return m ^ kr;
	endfunction

	function automatic csa_word_t model_result(input word_t blk, input csa_word_t din,
		input word_t times, input word_t start);
		csa_word_t key;
		csa_word_t s;
		key = {blk, ~blk};
		s = din;
		for (word_t r = start; r < times; r++) begin
			s = model_round(s, key, r);
		end
		return s;
	endfunction

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail %s %s: expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// caller sits 1 ns after an edge
	task automatic write_job(input word_t blk, input csa_word_t din, input word_t times,
		input word_t start);
		job_wr = 1'b1;
		job_block = blk;
		job_in = din;
		job_times = times;
		job_times_start = start;
		exp_block.push_back(blk);
		exp_in.push_back(din);
		exp_times.push_back(times);
		exp_start.push_back(start);
		step();
		job_wr = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_in.size() != 0) begin
			step();
		end
		repeat (2) step();
	endtask

	// result monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && calc_ready) begin
			if (exp_in.size() == 0) begin
				errors++;
				$display("calc_ready_o pulsed in test %s with no job outstanding", cur_test);
			end else begin
				check("calc_out_o", model_result(exp_block[0], exp_in[0], exp_times[0],
					exp_start[0]), calc_out);
				check("calc_block_o", exp_block.pop_front(), calc_block);
				check("calc_in_o", exp_in.pop_front(), calc_in);
				check("calc_times_o", exp_times.pop_front(), calc_times);
				check("calc_times_start_o", exp_start.pop_front(), calc_times_start);
				if (in_stream) begin
					if (have_prev) begin
						check("calc_in_o step", prev_in + 64'd1, calc_in);
					end
					prev_in = calc_in;
					have_prev = 1'b1;
				end
			end
		end
	end

	task automatic test_reset_idle();
		cur_test = "reset_idle";
		repeat (20) begin
			check("calc_ready_o", 64'd0, calc_ready);
			step();
		end
	endtask

	task automatic test_single_job();
		cur_test = "single_job";
		write_job(32'h4000_0001, 64'd1, 32'd9, 32'd4);
		wait_drain();
	endtask

	task automatic test_zero_rounds();
		cur_test = "zero_rounds";
		write_job(32'hcafe_f00d, 64'hdead_beef_0123_4567, 32'd3, 32'd5);
		write_job(32'h0bad_c0de, 64'h8899_aabb_ccdd_eeff, 32'd6, 32'd6);
		wait_drain();
	endtask

	task automatic measure_latency(input word_t times, input word_t start, input int n);
		int cycles;
		wait_drain();
		write_job(32'h1234_5678, 64'h0f1e_2d3c_4b5a_6978, times, start);
		cycles = 1;
		while (!calc_ready && cycles < n + 24) begin
			step();
			cycles++;
		end
		if (!calc_ready) begin
			errors++;
			$display("no calc_ready_o seen within %0d cycles of the write in %s",
				cycles, cur_test);
		end else begin
			check("latency", 64'(n + 4), 64'(cycles));
		end
		wait_drain();
	endtask

	task automatic test_latency();
		cur_test = "latency_n0";
		measure_latency(32'd2, 32'd2, 0);
		cur_test = "latency_n7";
		measure_latency(32'd7, 32'd0, 7);
	endtask

	task automatic test_stream();
		word_t blk;
		word_t start;
		word_t times;
		cur_test = "ordered_stream";
		in_stream = 1'b1;
		have_prev = 1'b0;
		for (int i = 0; i < stream_jobs; i++) begin
			blk = $random(seed);
			start = $unsigned($random(seed)) % 16;
			times = start + ($unsigned($random(seed)) % 16);
			write_job(blk, 64'd1 + 64'(i), times, start);
		end
		wait_drain();
		in_stream = 1'b0;
	endtask

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		job_wr = 1'b0;
		job_block = '0;
		job_in = '0;
		job_times = '0;
		job_times_start = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_idle();
		test_single_job();
		test_zero_rounds();
		test_latency();
		test_stream();
		wait_drain();
		sva_fails = i_dut.i_calc.i_sva.fail_count;
		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: csa_calc.f
rtl/csa_pkg.sv
rtl/csa_job_fifo.sv
rtl/csa_round.sv
rtl/csa_calc_logic.sv
rtl/csa_calc_top.sv
tb/clk_gen.sv
tb/csa_calc_sva.sv
tb/csa_calc_tb.sv

// File: Bender.yml
package:
  name: csa_calc

sources:
  - files:
      - rtl/csa_pkg.sv
      - rtl/csa_job_fifo.sv
      - rtl/csa_round.sv
      - rtl/csa_calc_logic.sv
      - rtl/csa_calc_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/csa_calc_sva.sv
      - tb/csa_calc_tb.sv
